//--- verilog/mcu_pkg.sv
// MCU shared definitions
// address map, register offsets, Wishbone and power bundles, interrupt word layout
`default_nettype none

package mcu_pkg;

  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int NUM_BANKS   = 4;
  localparam int BANK_WORDS  = 256;
  localparam int BANK_IDX_W  = 8;
  localparam int NUM_EXT_IRQ = 8;

  // region code from adr[13:12], code 3 unmapped
  localparam logic [1:0] REGION_RAM = 2'd0;
  localparam logic [1:0] REGION_PWR = 2'd1;
  localparam logic [1:0] REGION_IRQ = 2'd2;

  // word offsets, compared against adr[3:2]
  localparam logic [1:0] PWR_CTRL_OFS    = 2'd0;
  localparam logic [1:0] PWR_STATUS_OFS  = 2'd1;
  localparam logic [1:0] IRQ_PENDING_OFS = 2'd0;
  localparam logic [1:0] IRQ_ENABLE_OFS  = 2'd1;
  localparam logic [1:0] IRQ_SOFT_OFS    = 2'd2;

  // Wishbone classic, master to slave
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] dat;
  } wb_rsp_t;

  // per bank power outputs, all active low
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
  } bank_pwr_t;

  typedef struct packed {
    logic        rsvd_31;
    logic [14:0] fast;
    logic [3:0]  rsvd_15_12;
    logic        external;
    logic [6:0]  rsvd_10_4;
    logic        software;
    logic [2:0]  rsvd_2_0;
  } irq_fields_t;

  typedef union packed {
    logic [31:0] raw;
    irq_fields_t f;
  } irq_word_u;

endpackage

`default_nettype wire

//--- verilog/wb_decoder.sv
// Wishbone address decoder
// steers the single master to one target and muxes the response back
`timescale 1ns/1ps
`default_nettype none

module wb_decoder (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  mcu_pkg::wb_req_t wb_req_i,
  output mcu_pkg::wb_rsp_t wb_rsp_o,
  output mcu_pkg::wb_req_t ram_req_o,
  input  mcu_pkg::wb_rsp_t ram_rsp_i,
  output mcu_pkg::wb_req_t pwr_req_o,
  input  mcu_pkg::wb_rsp_t pwr_rsp_i,
  output mcu_pkg::wb_req_t irq_req_o,
  input  mcu_pkg::wb_rsp_t irq_rsp_i
);

  import mcu_pkg::*;

  logic [2:0] sel;
  logic [2:0] sel_q;
  logic       unmapped;
  logic       req_vld;
  logic       unm_ack_q;

  assign req_vld = wb_req_i.cyc & wb_req_i.stb;

  // one-hot target select, indexed by region code
  always_comb begin
    sel = '0;
    if (~|wb_req_i.adr[ADDR_W-1:14]) begin
      sel[REGION_RAM] = (wb_req_i.adr[13:12] == REGION_RAM);
      sel[REGION_PWR] = (wb_req_i.adr[13:12] == REGION_PWR);
      sel[REGION_IRQ] = (wb_req_i.adr[13:12] == REGION_IRQ);
    end
  end

  assign unmapped = ~|sel;

  always_comb begin
    ram_req_o     = wb_req_i;
    pwr_req_o     = wb_req_i;
    irq_req_o     = wb_req_i;
    ram_req_o.cyc = wb_req_i.cyc & sel[REGION_RAM];
    ram_req_o.stb = wb_req_i.stb & sel[REGION_RAM];
    pwr_req_o.cyc = wb_req_i.cyc & sel[REGION_PWR];
    pwr_req_o.stb = wb_req_i.stb & sel[REGION_PWR];
    irq_req_o.cyc = wb_req_i.cyc & sel[REGION_IRQ];
    irq_req_o.stb = wb_req_i.stb & sel[REGION_IRQ];
  end

  // request is held until ack, so the latched select is valid in the ack cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sel_q     <= '0;
      unm_ack_q <= 1'b0;
    end else begin
      if (req_vld) begin
        sel_q <= sel;
      end
      unm_ack_q <= req_vld & unmapped & ~unm_ack_q;
    end
  end

  always_comb begin
    if (sel_q[REGION_RAM]) begin
      wb_rsp_o = ram_rsp_i;
    end else if (sel_q[REGION_PWR]) begin
      wb_rsp_o = pwr_rsp_i;
    end else if (sel_q[REGION_IRQ]) begin
      wb_rsp_o = irq_rsp_i;
    end else begin
      wb_rsp_o.ack = unm_ack_q;
      wb_rsp_o.dat = '0;
    end
  end

endmodule

`default_nettype wire

//--- verilog/ram_banks.sv
// Banked word RAM
// bank picked by adr[11:10], accesses to an unpowered bank read 0 and drop writes
`timescale 1ns/1ps
`default_nettype none

module ram_banks (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  mcu_pkg::wb_req_t              req_i,
  output mcu_pkg::wb_rsp_t              rsp_o,
  input  logic [mcu_pkg::NUM_BANKS-1:0] bank_on_i
);

  import mcu_pkg::*;

  localparam int BANK_SEL_W = $clog2(NUM_BANKS);

  logic [DATA_W-1:0]     mem_q [NUM_BANKS][BANK_WORDS];
  logic [BANK_SEL_W-1:0] bank;
  logic [BANK_IDX_W-1:0] idx;
  logic                  access;
  logic                  ack_q;
  logic [DATA_W-1:0]     rdata_q;

  assign bank = req_i.adr[BANK_IDX_W+BANK_SEL_W+1:BANK_IDX_W+2];
  assign idx  = req_i.adr[BANK_IDX_W+1:2];

  // first cycle of a presented access
  assign access = req_i.cyc & req_i.stb & ~ack_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && req_i.we && bank_on_i[bank]) begin
      mem_q[bank][idx] <= req_i.dat;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= bank_on_i[bank] ? mem_q[bank][idx] : '0;
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.dat = rdata_q;

endmodule

`default_nettype wire

//--- verilog/power_manager.sv
// RAM bank power manager
// one power switch sequencer per bank, with control and status registers
`timescale 1ns/1ps
`default_nettype none

module power_manager (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  mcu_pkg::wb_req_t                            req_i,
  output mcu_pkg::wb_rsp_t                            rsp_o,
  output mcu_pkg::bank_pwr_t [mcu_pkg::NUM_BANKS-1:0] bank_pwr_o,
  input  logic [mcu_pkg::NUM_BANKS-1:0]               pwrgate_ack_ni,
  output logic [mcu_pkg::NUM_BANKS-1:0]               bank_on_o,
  output logic                                        pwr_done_o
);

  import mcu_pkg::*;

  typedef enum logic [2:0] {
    PWR_ON,
    PWR_ISO,
    PWR_GATE,
    PWR_OFF,
    PWR_UNGATE,
    PWR_RELEASE
  } pwr_state_e;

  logic [NUM_BANKS-1:0] ctrl_q;
  logic [NUM_BANKS-1:0] busy;
  logic [NUM_BANKS-1:0] done;
  logic [DATA_W-1:0]    status;
  logic [DATA_W-1:0]    rdata_q;
  logic [1:0]           ofs;
  logic                 access;
  logic                 ack_q;
  logic                 done_q;

  assign ofs    = req_i.adr[3:2];
  assign access = req_i.cyc & req_i.stb & ~ack_q;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    pwr_state_e state_q;

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        state_q <= PWR_ON;
      end else begin
        case (state_q)
          PWR_ON:      if (!ctrl_q[b]) state_q <= PWR_ISO;
          PWR_ISO:     state_q <= PWR_GATE;
          // switch cells report off with the ack low
          PWR_GATE:    if (!pwrgate_ack_ni[b]) state_q <= PWR_OFF;
          PWR_OFF:     if (ctrl_q[b]) state_q <= PWR_UNGATE;
          PWR_UNGATE:  if (pwrgate_ack_ni[b]) state_q <= PWR_RELEASE;
          PWR_RELEASE: state_q <= PWR_ON;
          default:     state_q <= PWR_ON;
        endcase
      end
    end

    assign bank_pwr_o[b] = '{
      pwrgate_en_n: !(state_q inside {PWR_GATE, PWR_OFF}),
      isogate_en_n: (state_q inside {PWR_ON, PWR_RELEASE}),
      rst_n:        (state_q == PWR_ON)
    };

    assign bank_on_o[b] = (state_q == PWR_ON);
    assign busy[b]      = !(state_q inside {PWR_ON, PWR_OFF});
    assign done[b]      = ((state_q == PWR_GATE) && !pwrgate_ack_ni[b]) ||
                          (state_q == PWR_RELEASE);
  end

  always_comb begin
    status                  = '0;
    status[NUM_BANKS-1:0]   = bank_on_o;
    // busy flag
    status[8]               = |busy;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_q <= '1;
      ack_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      ack_q  <= access;
      done_q <= |done;
      if (access && req_i.we && (ofs == PWR_CTRL_OFS)) begin
        ctrl_q <= req_i.dat[NUM_BANKS-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      case (ofs)
        PWR_CTRL_OFS:   rdata_q <= {{(DATA_W-NUM_BANKS){1'b0}}, ctrl_q};
        PWR_STATUS_OFS: rdata_q <= status;
        default:        rdata_q <= '0;
      endcase
    end
  end

  assign rsp_o.ack  = ack_q;
  assign rsp_o.dat  = rdata_q;
  assign pwr_done_o = done_q;

endmodule

`default_nettype wire

//--- verilog/irq_ctrl.sv
// Interrupt controller
// builds the machine interrupt word, latches it into pending, masks with enable
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  mcu_pkg::wb_req_t                req_i,
  output mcu_pkg::wb_rsp_t                rsp_o,
  input  logic                            plic_irq_i,
  input  logic [mcu_pkg::NUM_EXT_IRQ-1:0] ext_irq_i,
  input  logic                            pwr_done_i,
  output logic                            irq_o
);

  import mcu_pkg::*;

  irq_word_u         src;
  logic [31:0]       pending_q;
  logic [31:0]       pending_d;
  logic [31:0]       enable_q;
  logic [31:0]       enable_d;
  logic [31:0]       clr;
  logic              soft_q;
  logic              soft_d;
  logic [1:0]        ofs;
  logic              access;
  logic              wr;
  logic              ack_q;
  logic              irq_q;
  logic [DATA_W-1:0] rdata_q;

  assign ofs    = req_i.adr[3:2];
  assign access = req_i.cyc & req_i.stb & ~ack_q;
  assign wr     = access & req_i.we;

  // reserved fields stay zero
  always_comb begin
    src.raw                      = '0;
    src.f.software               = soft_q;
    src.f.external               = plic_irq_i;
    src.f.fast[NUM_EXT_IRQ:0]    = {ext_irq_i, pwr_done_i};
  end

  // write-one-to-clear wins, a held source sets it again next cycle
  always_comb begin
    clr       = (wr && (ofs == IRQ_PENDING_OFS)) ? req_i.dat : '0;
    pending_d = (pending_q | src.raw) & ~clr;
    enable_d  = (wr && (ofs == IRQ_ENABLE_OFS)) ? req_i.dat : enable_q;
    soft_d    = (wr && (ofs == IRQ_SOFT_OFS)) ? req_i.dat[0] : soft_q;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
      soft_q    <= 1'b0;
      ack_q     <= 1'b0;
      irq_q     <= 1'b0;
    end else begin
      pending_q <= pending_d;
      enable_q  <= enable_d;
      soft_q    <= soft_d;
      ack_q     <= access;
      // matches the registers as they are after this edge
      irq_q     <= |(pending_d & enable_d);
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      case (ofs)
        IRQ_PENDING_OFS: rdata_q <= pending_q;
        IRQ_ENABLE_OFS:  rdata_q <= enable_q;
        IRQ_SOFT_OFS:    rdata_q <= {{(DATA_W-1){1'b0}}, soft_q};
        default:         rdata_q <= '0;
      endcase
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.dat = rdata_q;
  assign irq_o     = irq_q;

endmodule

`default_nettype wire

//--- verilog/mcu_top.sv
// MCU top level
// Wishbone decoder, banked RAM, bank power manager and interrupt block
`timescale 1ns/1ps
`default_nettype none

module mcu_top (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  mcu_pkg::wb_req_t                              wb_req_i,
  output mcu_pkg::wb_rsp_t                              wb_rsp_o,
  output mcu_pkg::bank_pwr_t [mcu_pkg::NUM_BANKS-1:0]   bank_pwr_o,
  input  logic [mcu_pkg::NUM_BANKS-1:0]                 pwrgate_ack_ni,
  input  logic                                          plic_irq_i,
  input  logic [mcu_pkg::NUM_EXT_IRQ-1:0]               ext_irq_i,
  output logic                                          irq_o
);

  import mcu_pkg::*;

  wb_req_t ram_req;
  wb_rsp_t ram_rsp;
  wb_req_t pwr_req;
  wb_rsp_t pwr_rsp;
  wb_req_t irq_req;
  wb_rsp_t irq_rsp;

  logic [NUM_BANKS-1:0] bank_on;
  logic                 pwr_done;

  wb_decoder wb_decoder_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .wb_req_i  (wb_req_i),
    .wb_rsp_o  (wb_rsp_o),
    .ram_req_o (ram_req),
    .ram_rsp_i (ram_rsp),
    .pwr_req_o (pwr_req),
    .pwr_rsp_i (pwr_rsp),
    .irq_req_o (irq_req),
    .irq_rsp_i (irq_rsp)
  );

  ram_banks ram_banks_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (ram_req),
    .rsp_o     (ram_rsp),
    .bank_on_i (bank_on)
  );

  power_manager power_manager_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_i          (pwr_req),
    .rsp_o          (pwr_rsp),
    .bank_pwr_o     (bank_pwr_o),
    .pwrgate_ack_ni (pwrgate_ack_ni),
    .bank_on_o      (bank_on),
    .pwr_done_o     (pwr_done)
  );

  irq_ctrl irq_ctrl_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (irq_req),
    .rsp_o      (irq_rsp),
    .plic_irq_i (plic_irq_i),
    .ext_irq_i  (ext_irq_i),
    .pwr_done_i (pwr_done),
    .irq_o      (irq_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_mcu_assertions.sv
// Bus and power protocol assertions
// bound into the MCU top level
`timescale 1ns/1ps
`default_nettype none

module tb_mcu_assertions (
  input logic                                        clk_i,
  input logic                                        rst_n_i,
  input mcu_pkg::wb_req_t                            wb_req_i,
  input mcu_pkg::wb_rsp_t                            wb_rsp_i,
  input mcu_pkg::bank_pwr_t [mcu_pkg::NUM_BANKS-1:0] bank_pwr_i,
  input logic                                        irq_i,
  input logic [31:0]                                 pending_i,
  input logic [31:0]                                 enable_i
);

  import mcu_pkg::*;

  ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb)) else $error("ack outside a bus cycle");

  ack_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_rsp_i.ack |=> !wb_rsp_i.ack) else $error("ack held for two cycles");

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_iso
    gate_needs_iso: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !bank_pwr_i[b].pwrgate_en_n |-> !bank_pwr_i[b].isogate_en_n)
      else $error("bank gated without isolation");
  end

  irq_masked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_i |-> |(pending_i & enable_i)) else $error("irq without enabled pending bit");

endmodule

`default_nettype wire

//--- testbench/tb_mcu_top.sv
// MCU top level testbench
// random Wishbone traffic, power switch ack model and reference model checks
`timescale 1ns/1ps
`default_nettype none

module tb_mcu_top;

  import mcu_pkg::*;

  localparam int          TOTAL_WORDS  = NUM_BANKS * BANK_WORDS;
  localparam int          ACK_TIMEOUT  = 20;
  localparam int          BUSY_TIMEOUT = 100;
  localparam logic [31:0] SEED         = 32'hc70b_10b3;
  localparam logic [31:0] PWR_CTRL_ADR = 32'h0000_1000;
  localparam logic [31:0] PWR_STAT_ADR = 32'h0000_1004;
  localparam logic [31:0] IRQ_PEND_ADR = 32'h0000_2000;
  localparam logic [31:0] IRQ_EN_ADR   = 32'h0000_2004;
  localparam logic [31:0] IRQ_SOFT_ADR = 32'h0000_2008;

  logic                            clk_i;
  logic                            rst_n_i;
  wb_req_t                         wb_req;
  wb_rsp_t                         wb_rsp;
  bank_pwr_t [NUM_BANKS-1:0]       bank_pwr;
  logic [NUM_BANKS-1:0]            ack_n = '1;
  logic                            plic_irq;
  logic [NUM_EXT_IRQ-1:0]          ext_irq;
  logic                            irq;

  logic [31:0]          ram_m [TOTAL_WORDS];
  logic [NUM_BANKS-1:0] on_m;
  logic [31:0]          pend_m;
  logic [31:0]          en_m;
  logic [31:0]          rnd_state = SEED;
  logic [31:0]          ack_state = SEED;
  logic [3:0]           ack_cnt [NUM_BANKS];
  int                   checks;
  int                   errors;

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  mcu_top mcu_top_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .wb_req_i       (wb_req),
    .wb_rsp_o       (wb_rsp),
    .bank_pwr_o     (bank_pwr),
    .pwrgate_ack_ni (ack_n),
    .plic_irq_i     (plic_irq),
    .ext_irq_i      (ext_irq),
    .irq_o          (irq)
  );

  bind mcu_top tb_mcu_assertions tb_mcu_assertions_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wb_req_i   (wb_req_i),
    .wb_rsp_i   (wb_rsp_o),
    .bank_pwr_i (bank_pwr_o),
    .irq_i      (irq_o),
    .pending_i  (irq_ctrl_inst.pending_q),
    .enable_i   (irq_ctrl_inst.enable_q)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // whole word index folded in, so every address gets its own value
  function automatic logic [31:0] fill_pattern(input int w);
    return (w * 32'h9e37_79b9) ^ 32'h5a5a_0000 ^ w;
  endfunction

  // switch cells follow the gate enable 1 to 8 cycles later
  always @(posedge clk_i) begin : ack_model
    if (!rst_n_i) begin
      for (int b = 0; b < NUM_BANKS; b++) ack_cnt[b] <= 4'd0;
      ack_n <= '1;
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (ack_cnt[b] != 4'd0) begin
          ack_cnt[b] <= ack_cnt[b] - 4'd1;
          if (ack_cnt[b] == 4'd1) ack_n[b] <= bank_pwr[b].pwrgate_en_n;
        end else if (ack_n[b] != bank_pwr[b].pwrgate_en_n) begin
          ack_state = lcg_next(ack_state);
          ack_cnt[b] <= {1'b0, ack_state[18:16]} + 4'd1;
        end
      end
    end
  end

  task automatic get_rand(output logic [31:0] r);
    rnd_state = lcg_next(rnd_state);
    r = rnd_state;
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // an off bank is gated, isolated and held in reset
  task automatic check_bank_pwr();
    for (int k = 0; k < NUM_BANKS; k++) begin
      check_eq($sformatf("bank_pwr[%0d]", k), {29'b0, bank_pwr[k]},
               on_m[k] ? 32'h7 : 32'h0);
    end
  endtask

  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
    int   cnt;
    logic got;
    @(posedge clk_i);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    cnt = 0;
    got = 1'b0;
    while (!got && cnt < ACK_TIMEOUT) begin
      @(negedge clk_i);
      cnt++;
      got = wb_rsp.ack;
    end
    rdat = wb_rsp.dat;
    checks++;
    if (!got) begin
      errors++;
      $display("bus access to address %h was never acknowledged", adr);
    end else if (cnt != 2) begin
      errors++;
      $display("** Error at %0t: ack latency = %0d, expected 2", $time, cnt);
    end
    @(posedge clk_i);
    wb_req.cyc <= 1'b0;
    wb_req.stb <= 1'b0;
  endtask

  task automatic write_word(input logic [31:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    bus_access(1'b1, adr, dat, unused);
  endtask

  task automatic read_word(input logic [31:0] adr, output logic [31:0] dat);
    bus_access(1'b0, adr, 32'h0, dat);
  endtask

  task automatic fill_bank(input int b);
    int w;
    for (int i = 0; i < BANK_WORDS; i++) begin
      w = b * BANK_WORDS + i;
      write_word(w * 4, fill_pattern(w));
      ram_m[w] = fill_pattern(w);
    end
  endtask

  task automatic random_ram_ops(input int n);
    logic [31:0] r;
    logic [31:0] d;
    int          w;
    for (int i = 0; i < n; i++) begin
      get_rand(r);
      w = int'(r[9:0]);
      if (r[31]) begin
        get_rand(d);
        write_word(w * 4, d);
        if (on_m[r[9:8]]) ram_m[w] = d;
      end else begin
        read_word(w * 4, d);
        check_eq("ram rdata", d, on_m[r[9:8]] ? ram_m[w] : 32'h0);
      end
    end
  endtask

  // one sequence, then the done pulse must show up as fast bit 0
  task automatic set_bank_power(input int b, input logic on);
    logic [31:0] d;
    int          cnt;
    logic [NUM_BANKS-1:0] ctrl;
    ctrl = on_m;
    ctrl[b] = on;
    write_word(PWR_CTRL_ADR, {{(32-NUM_BANKS){1'b0}}, ctrl});
    cnt = 0;
    d = 32'h100;
    while (d[8] && cnt < BUSY_TIMEOUT) begin
      read_word(PWR_STAT_ADR, d);
      cnt++;
    end
    checks++;
    if (d[8]) begin
      errors++;
      $display("power sequence of bank %0d did not finish", b);
    end
    on_m = ctrl;
    check_eq("pwr_status", d, {{(32-NUM_BANKS){1'b0}}, on_m});
    check_bank_pwr();
    read_word(IRQ_PEND_ADR, d);
    check_eq("irq_pending", d, 32'h0001_0000);
    write_word(IRQ_PEND_ADR, 32'h0001_0000);
  endtask

  task automatic irq_step();
    logic [31:0] r;
    logic [31:0] d;
    get_rand(r);
    case (r[1:0])
      2'd0: begin
        @(posedge clk_i);
        ext_irq  <= r[15:8];
        plic_irq <= r[16];
        @(posedge clk_i);
        ext_irq  <= '0;
        plic_irq <= 1'b0;
        pend_m = pend_m | {7'b0, r[15:8], 17'b0} | {20'b0, r[16], 11'b0};
      end
      2'd1: begin
        write_word(IRQ_SOFT_ADR, 32'h1);
        write_word(IRQ_SOFT_ADR, 32'h0);
        pend_m = pend_m | 32'h8;
      end
      2'd2: begin
        get_rand(d);
        write_word(IRQ_EN_ADR, d);
        en_m = d;
      end
      default: begin
        get_rand(d);
        write_word(IRQ_PEND_ADR, d);
        pend_m = pend_m & ~d;
      end
    endcase
    read_word(IRQ_PEND_ADR, d);
    check_eq("irq_pending", d, pend_m);
    @(negedge clk_i);
    check_eq("irq_o", {31'b0, irq}, {31'b0, |(pend_m & en_m)});
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] d;
    int          b;
    rst_n_i  = 1'b0;
    wb_req   = '0;
    plic_irq = 1'b0;
    ext_irq  = '0;
    checks   = 0;
    errors   = 0;
    on_m     = '1;
    pend_m   = 32'h0;
    en_m     = 32'h0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    // reset state: banks powered, no ack, no interrupt
    check_bank_pwr();
    check_eq("wb ack", {31'b0, wb_rsp.ack}, 32'h0);
    check_eq("irq_o", {31'b0, irq}, 32'h0);

    for (int i = 0; i < NUM_BANKS; i++) fill_bank(i);
    random_ram_ops(200);

    // unmapped region code 3 and addresses above bit 14
    for (int i = 0; i < 6; i++) begin
      get_rand(r);
      d = (i == 0) ? 32'h0000_3000 : (r | 32'h0000_4000);
      read_word(d, r);
      check_eq("unmapped rdata", r, 32'h0);
      write_word(d, r ^ 32'hffff_ffff);
      // the RAM word with the same low address bits is untouched
      read_word(d & 32'h0000_0ffc, r);
      check_eq("ram rdata", r, ram_m[d[11:2]]);
    end
    random_ram_ops(100);

    write_word(IRQ_PEND_ADR, 32'hffff_ffff);
    get_rand(r);
    b = int'(r[1:0]);
    set_bank_power(b, 1'b0);
    random_ram_ops(150);
    set_bank_power(b, 1'b1);
    fill_bank(b);
    random_ram_ops(150);

    for (int i = 0; i < 40; i++) irq_step();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
verilog/mcu_pkg.sv
verilog/wb_decoder.sv
verilog/ram_banks.sv
verilog/power_manager.sv
verilog/irq_ctrl.sv
verilog/mcu_top.sv
testbench/tb_mcu_assertions.sv
testbench/tb_mcu_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_mcu_top -f sim.f -o tb_mcu_top
output=$(./obj_dir/tb_mcu_top)
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
